/* rtl/mipsPkg.sv */
package mipsPkg;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    // Primary opcode field in instr[31:26]
    typedef enum logic [5:0] {
        OpSpecial  = 6'h00,
        OpRegimm   = 6'h01,
        OpJ        = 6'h02,
        OpJal      = 6'h03,
        OpBeq      = 6'h04,
        OpBne      = 6'h05,
        OpBlez     = 6'h06,
        OpBgtz     = 6'h07,
        OpAddi     = 6'h08,
        OpSlti     = 6'h0A,
        OpAndi     = 6'h0C,
        OpOri      = 6'h0D,
        OpXori     = 6'h0E,
        OpSpecial2 = 6'h1C,
        OpLb       = 6'h20,
        OpLh       = 6'h21,
        OpLw       = 6'h23,
        OpSb       = 6'h28,
        OpSh       = 6'h29,
        OpSw       = 6'h2B
    } opcodeE;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluNor,
        AluSlt,
        AluSll,
        AluSrl,
        AluMul
    } aluOpE;

    typedef enum logic [2:0] {
        BrNone,
        BrEq,
        BrNe,
        BrGtz,
        BrLez,
        BrGez,
        BrLtz
    } branchKindE;

    typedef enum logic [1:0] {
        MemByte,
        MemHalf,
        MemWord
    } memSizeE;

    // Which instruction field names the destination
    typedef enum logic [1:0] {
        DestRd,
        DestRt,
        DestLink
    } destSelE;

    //////////////////////////////////////////////////
    // Pipeline payloads
    //////////////////////////////////////////////////

    typedef struct packed {
        logic       regWrite;
        aluOpE      aluOp;
        logic       aluSrc;
        logic       immZero;
        destSelE    destSel;
        logic       memRead;
        logic       memWrite;
        memSizeE    memSize;
        branchKindE branchKind;
        logic       jump;
        logic       jumpReg;
        logic       link;
    } ctrlT;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        ctrlT        ctrl;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [4:0]  rsIdx;
        logic [4:0]  rtIdx;
        logic [31:0] imm;
        logic [4:0]  shamt;
        logic [25:0] jumpIdx;
        logic [4:0]  dest;
    } decExT;

    typedef struct packed {
        logic        valid;
        ctrlT        ctrl;
        logic [31:0] aluRes;
        logic [31:0] storeVal;
        logic [4:0]  dest;
        logic        redirect;
        logic [31:0] target;
    } exMemT;

    // Register write as seen at the end of the pipe
    typedef struct packed {
        logic        valid;
        logic [4:0]  regIdx;
        logic [31:0] data;
    } wbT;

endpackage

/* rtl/controlDecoder.sv */
`timescale 1ns/10ps

module controlDecoder
    import mipsPkg::*;
(
    input  opcodeE     opcode,
    input  logic [5:0] funct,
    input  logic [4:0] rtField,
    output ctrlT       ctrl
);

    // Function field codes under SPECIAL and SPECIAL2
    localparam logic [5:0] FnSll = 6'h00;
    localparam logic [5:0] FnSrl = 6'h02;
    localparam logic [5:0] FnJr  = 6'h08;
    localparam logic [5:0] FnAdd = 6'h20;
    localparam logic [5:0] FnSub = 6'h22;
    localparam logic [5:0] FnAnd = 6'h24;
    localparam logic [5:0] FnOr  = 6'h25;
    localparam logic [5:0] FnXor = 6'h26;
    localparam logic [5:0] FnNor = 6'h27;
    localparam logic [5:0] FnSlt = 6'h2A;
    localparam logic [5:0] FnMul = 6'h02;

    always_comb begin
        // Everything off so unknown encodings fall through as no-ops
        ctrl = '0;

        case (opcode)
            OpSpecial: begin
                if (funct == FnJr) begin
                    ctrl.jumpReg = 1'b1;
                end else begin
                    ctrl.regWrite = 1'b1;
                    ctrl.destSel  = DestRd;
                    case (funct)
                        FnAdd:   ctrl.aluOp = AluAdd;
                        FnSub:   ctrl.aluOp = AluSub;
                        FnAnd:   ctrl.aluOp = AluAnd;
                        FnOr:    ctrl.aluOp = AluOr;
                        FnXor:   ctrl.aluOp = AluXor;
                        FnNor:   ctrl.aluOp = AluNor;
                        FnSlt:   ctrl.aluOp = AluSlt;
                        FnSll:   ctrl.aluOp = AluSll;
                        FnSrl:   ctrl.aluOp = AluSrl;
                        default: ctrl.regWrite = 1'b0;
                    endcase
                end
            end

            OpSpecial2: begin
                if (funct == FnMul) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.destSel  = DestRd;
                    ctrl.aluOp    = AluMul;
                end
            end

            // Immediate ALU group writes rt
            OpAddi, OpSlti, OpAndi, OpOri, OpXori: begin
                ctrl.regWrite = 1'b1;
                ctrl.destSel  = DestRt;
                ctrl.aluSrc   = 1'b1;
                case (opcode)
                    OpAddi:  ctrl.aluOp = AluAdd;
                    OpSlti:  ctrl.aluOp = AluSlt;
                    OpAndi:  ctrl.aluOp = AluAnd;
                    OpOri:   ctrl.aluOp = AluOr;
                    default: ctrl.aluOp = AluXor;
                endcase
                ctrl.immZero = (opcode == OpAndi) || (opcode == OpOri) || (opcode == OpXori);
            end

            // Loads and stores address rs + imm
            OpLb, OpLh, OpLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.destSel  = DestRt;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memSize  = (opcode == OpLb) ? MemByte :
                                (opcode == OpLh) ? MemHalf : MemWord;
            end
            OpSb, OpSh, OpSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.memSize  = (opcode == OpSb) ? MemByte :
                                (opcode == OpSh) ? MemHalf : MemWord;
            end

            // Branches only name the condition
            OpBeq:  ctrl.branchKind = BrEq;
            OpBne:  ctrl.branchKind = BrNe;
            OpBgtz: ctrl.branchKind = BrGtz;
            OpBlez: ctrl.branchKind = BrLez;
            OpRegimm: begin
                case (rtField)
                    5'd1:    ctrl.branchKind = BrGez;
                    5'd0:    ctrl.branchKind = BrLtz;
                    default: ctrl.branchKind = BrNone;
                endcase
            end

            OpJ: ctrl.jump = 1'b1;
            OpJal: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.destSel  = DestLink;
            end

            default: ctrl = '0;
        endcase
    end

    // A single access per instruction
    assert final (!(ctrl.memRead && ctrl.memWrite))
        else $error("controlDecoder: load and store both requested");

endmodule

/* rtl/decodeStage.sv */
`timescale 1ns/10ps

module decodeStage
    import mipsPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic        instrValid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  wbT          wb,
    output decExT       decEx
);

    logic [31:0] regFile [32];

    ctrlT        ctrl;
    logic [4:0]  rsIdx;
    logic [4:0]  rtIdx;
    logic [31:0] rsRead;
    logic [31:0] rtRead;
    logic [31:0] immExt;
    logic [4:0]  dest;
    decExT       decNext;

    assign rsIdx = instr[25:21];
    assign rtIdx = instr[20:16];

    controlDecoder ctrlDec (
        .opcode  (opcodeE'(instr[31:26])),
        .funct   (instr[5:0]),
        .rtField (rtIdx),
        .ctrl    (ctrl)
    );

    //////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////

    // Register 0 stays zero as wb never targets it
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regFile <= '{default: '0};
        end else if (wb.valid) begin
            regFile[wb.regIdx] <= wb.data;
        end
    end

    // Write-through so the same-edge write is seen
    assign rsRead = (wb.valid && wb.regIdx == rsIdx) ? wb.data : regFile[rsIdx];
    assign rtRead = (wb.valid && wb.regIdx == rtIdx) ? wb.data : regFile[rtIdx];

    //////////////////////////////////////////////////
    // Immediate and destination
    //////////////////////////////////////////////////

    assign immExt = ctrl.immZero ? {16'h0000, instr[15:0]}
                                 : {{16{instr[15]}}, instr[15:0]};

    always_comb begin
        case (ctrl.destSel)
            DestRd:   dest = instr[15:11];
            DestRt:   dest = rtIdx;
            DestLink: dest = 5'd31;
            default:  dest = 5'd0;
        endcase
    end

    always_comb begin
        decNext.valid   = instrValid;
        decNext.pc      = pc;
        decNext.ctrl    = ctrl;
        decNext.rsVal   = rsRead;
        decNext.rtVal   = rtRead;
        decNext.rsIdx   = rsIdx;
        decNext.rtIdx   = rtIdx;
        decNext.imm     = immExt;
        decNext.shamt   = instr[10:6];
        decNext.jumpIdx = instr[25:0];
        decNext.dest    = dest;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decEx <= '0;
        end else begin
            decEx <= decNext;
        end
    end

    zeroRegStaysZero: assert property (
        @(posedge clk) disable iff (!arstN) regFile[0] == 32'h0
    ) else $error("decodeStage: register 0 holds a nonzero value");

endmodule

/* rtl/executeStage.sv */
`timescale 1ns/10ps

module executeStage
    import mipsPkg::*;
(
    input  logic  clk,
    input  logic  arstN,
    input  decExT decEx,
    input  wbT    fwd,
    output exMemT exMem
);

    logic [31:0] rsOp;
    logic [31:0] rtOp;
    logic [31:0] opB;
    logic [31:0] aluOut;
    logic [31:0] pcPlus4;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic        taken;
    exMemT       exNext;

    // Result of the instruction one ahead including load data
    assign rsOp = (fwd.valid && fwd.regIdx == decEx.rsIdx) ? fwd.data : decEx.rsVal;
    assign rtOp = (fwd.valid && fwd.regIdx == decEx.rtIdx) ? fwd.data : decEx.rtVal;

    assign opB = decEx.ctrl.aluSrc ? decEx.imm : rtOp;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    always_comb begin
        case (decEx.ctrl.aluOp)
            AluAdd:  aluOut = rsOp + opB;
            AluSub:  aluOut = rsOp - opB;
            AluAnd:  aluOut = rsOp & opB;
            AluOr:   aluOut = rsOp | opB;
            AluXor:  aluOut = rsOp ^ opB;
            AluNor:  aluOut = ~(rsOp | opB);
            AluSlt:  aluOut = {31'b0, $signed(rsOp) < $signed(opB)};
            // Shifts act on rt
            AluSll:  aluOut = opB << decEx.shamt;
            AluSrl:  aluOut = opB >> decEx.shamt;
            // Low word of the product
            AluMul:  aluOut = rsOp * opB;
            default: aluOut = 32'h0;
        endcase
    end

    //////////////////////////////////////////////////
    // Branch and jump resolution
    //////////////////////////////////////////////////

    assign pcPlus4      = decEx.pc + 32'd4;
    assign branchTarget = pcPlus4 + {decEx.imm[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], decEx.jumpIdx, 2'b00};

    always_comb begin
        case (decEx.ctrl.branchKind)
            BrEq:    taken = (rsOp == rtOp);
            BrNe:    taken = (rsOp != rtOp);
            BrGtz:   taken = ($signed(rsOp) > 0);
            BrLez:   taken = ($signed(rsOp) <= 0);
            BrGez:   taken = !rsOp[31];
            BrLtz:   taken = rsOp[31];
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        exNext.valid    = decEx.valid;
        exNext.ctrl     = decEx.ctrl;
        // jal links to the instruction after the delay slot position
        exNext.aluRes   = decEx.ctrl.link ? decEx.pc + 32'd8 : aluOut;
        exNext.storeVal = rtOp;
        exNext.dest     = decEx.dest;
        exNext.redirect = decEx.valid &&
                          (taken || decEx.ctrl.jump || decEx.ctrl.jumpReg);
        if (decEx.ctrl.jumpReg) begin
            exNext.target = rsOp;
        end else if (decEx.ctrl.jump) begin
            exNext.target = jumpTarget;
        end else begin
            exNext.target = branchTarget;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMem <= '0;
        end else begin
            exMem <= exNext;
        end
    end

    // Bubbles must never steer the fetcher
    redirectOnlyValid: assert property (
        @(posedge clk) disable iff (!arstN) exMem.redirect |-> exMem.valid
    ) else $error("executeStage: redirect raised on a bubble");

endmodule

/* rtl/memoryStage.sv */
`timescale 1ns/10ps

module memoryStage
    import mipsPkg::*;
#(
    parameter int DataWords = 256
) (
    input  logic  clk,
    input  logic  arstN,
    input  exMemT exMem,
    output wbT    wb
);

    localparam int AddrBits = $clog2(DataWords);

    logic [31:0] dataMem [DataWords];

    logic [AddrBits-1:0] wordAddr;
    logic [1:0]          byteOff;
    logic [31:0]         rdWord;
    logic [7:0]          byteLane;
    logic [15:0]         halfLane;
    logic [31:0]         loadVal;
    logic [3:0]          byteEn;
    logic [31:0]         storeData;

    // Address wraps on the memory size
    assign wordAddr = exMem.aluRes[AddrBits+1:2];
    assign byteOff  = exMem.aluRes[1:0];

    //////////////////////////////////////////////////
    // Load path with asynchronous read
    //////////////////////////////////////////////////

    assign rdWord   = dataMem[wordAddr];
    assign byteLane = rdWord[{byteOff, 3'b000} +: 8];
    assign halfLane = rdWord[{byteOff[1], 4'b0000} +: 16];

    always_comb begin
        case (exMem.ctrl.memSize)
            MemByte: loadVal = {{24{byteLane[7]}}, byteLane};
            MemHalf: loadVal = {{16{halfLane[15]}}, halfLane};
            default: loadVal = rdWord;
        endcase
    end

    //////////////////////////////////////////////////
    // Store path
    //////////////////////////////////////////////////

    always_comb begin
        case (exMem.ctrl.memSize)
            MemByte: begin
                byteEn    = 4'b0001 << byteOff;
                storeData = {4{exMem.storeVal[7:0]}};
            end
            MemHalf: begin
                byteEn    = byteOff[1] ? 4'b1100 : 4'b0011;
                storeData = {2{exMem.storeVal[15:0]}};
            end
            default: begin
                byteEn    = 4'b1111;
                storeData = exMem.storeVal;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (exMem.valid && exMem.ctrl.memWrite) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) begin
                    dataMem[wordAddr][8*b +: 8] <= storeData[8*b +: 8];
                end
            end
        end
    end

    // Writeback drops register 0
    assign wb.valid  = exMem.valid && exMem.ctrl.regWrite && (exMem.dest != 5'd0);
    assign wb.regIdx = exMem.dest;
    assign wb.data   = exMem.ctrl.memRead ? loadVal : exMem.aluRes;

    storeNeverWrites: assert property (
        @(posedge clk) disable iff (!arstN)
        (exMem.valid && exMem.ctrl.memWrite) |-> !wb.valid
    ) else $error("memoryStage: store produced a register write");

endmodule

/* rtl/mipsCore.sv */
`timescale 1ns/10ps

module mipsCore
    import mipsPkg::*;
#(
    parameter int DataWords = 256
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        instrValid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    output logic        redirectValid,
    output logic [31:0] redirectPc,
    output wbT          wb
);

    decExT decEx;
    exMemT exMem;

    decodeStage decode (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .wb         (wb),
        .decEx      (decEx)
    );

    // Forwarding taps the same writeback bus
    executeStage execute (
        .clk   (clk),
        .arstN (arstN),
        .decEx (decEx),
        .fwd   (wb),
        .exMem (exMem)
    );

    memoryStage #(
        .DataWords (DataWords)
    ) memory (
        .clk   (clk),
        .arstN (arstN),
        .exMem (exMem),
        .wb    (wb)
    );

    assign redirectValid = exMem.redirect;
    assign redirectPc    = exMem.target;

endmodule

/* test/coreTb.sv */
`timescale 1ns/10ps

module coreTb
    import mipsPkg::*;
();

    localparam int ClkPeriod   = 4;
    localparam int ResetCycles = 5;

    // One fetch slot as presented to the core
    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc;
    } slotT;

    // Expected outputs for one slot tagged by issue cycle
    typedef struct packed {
        logic [31:0] cycle;
        logic [2:0]  secId;
        logic        wbValid;
        logic [4:0]  wbReg;
        logic [31:0] wbData;
        logic        redir;
        logic [31:0] target;
    } expT;

    logic        clk;
    logic        arstN;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        redirectValid;
    logic [31:0] redirectPc;
    wbT          wb;

    slotT        progQ [$];
    expT         expQ [$];
    logic [31:0] modelReg [32];
    logic [31:0] modelMem [256];
    logic [31:0] genPc;
    logic [2:0]  curSec;
    expT         exp0;
    expT         exp1;
    expT         exp2;

    string sectionName [6] = '{"reset and bubbles", "register ops", "immediates",
                               "loads and stores", "branches", "jumps"};

    mipsCore #(
        .DataWords (256)
    ) UUT (
        .clk           (clk),
        .arstN         (arstN),
        .instrValid    (instrValid),
        .instr         (instr),
        .pc            (pc),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .wb            (wb)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // Encoding helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Stopping after the first error");
    endtask

    //////////////////////////////////////////////////
    // Golden ISA model
    //////////////////////////////////////////////////

    task automatic runModel(input slotT s, output expT e);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] se;
        logic [31:0] ze;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] val;
        logic [7:0]  bt;
        logic [15:0] hw;
        logic [4:0]  dst;
        logic        wr;
        logic        isBranch;
        logic        taken;
        e = '0;
        if (s.valid) begin
            {op, rs, rt, rd, sh, fn} = s.instr;
            a        = modelReg[rs];
            b        = modelReg[rt];
            se       = {{16{s.instr[15]}}, s.instr[15:0]};
            ze       = {16'h0000, s.instr[15:0]};
            addr     = a + se;
            word     = modelMem[addr[9:2]];
            bt       = 8'(word >> (8 * addr[1:0]));
            hw       = addr[1] ? word[31:16] : word[15:0];
            wr       = 1'b1;
            dst      = rt;
            val      = 32'h0;
            isBranch = 1'b0;
            taken    = 1'b0;
            case (op)
                6'h00: begin
                    dst = rd;
                    case (fn)
                        6'h20:   val = a + b;
                        6'h22:   val = a - b;
                        6'h24:   val = a & b;
                        6'h25:   val = a | b;
                        6'h26:   val = a ^ b;
                        6'h27:   val = ~(a | b);
                        6'h2A:   val = {31'b0, $signed(a) < $signed(b)};
                        6'h00:   val = b << sh;
                        6'h02:   val = b >> sh;
                        6'h08: begin
                            wr       = 1'b0;
                            e.redir  = 1'b1;
                            e.target = a;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                6'h1C: begin
                    dst = rd;
                    wr  = (fn == 6'h02);
                    val = a * b;
                end
                6'h08: val = a + se;
                6'h0A: val = {31'b0, $signed(a) < $signed(se)};
                6'h0C: val = a & ze;
                6'h0D: val = a | ze;
                6'h0E: val = a ^ ze;
                6'h20: val = {{24{bt[7]}}, bt};
                6'h21: val = {{16{hw[15]}}, hw};
                6'h23: val = word;
                6'h28, 6'h29, 6'h2B: begin
                    wr = 1'b0;
                    if (op == 6'h28) begin
                        modelMem[addr[9:2]][8 * addr[1:0] +: 8] = b[7:0];
                    end else if (op == 6'h29) begin
                        modelMem[addr[9:2]][16 * addr[1] +: 16] = b[15:0];
                    end else begin
                        modelMem[addr[9:2]] = b;
                    end
                end
                6'h04, 6'h05, 6'h06, 6'h07, 6'h01: begin
                    wr       = 1'b0;
                    isBranch = 1'b1;
                    case (op)
                        6'h04:   taken = (a == b);
                        6'h05:   taken = (a != b);
                        6'h06:   taken = ($signed(a) <= 0);
                        6'h07:   taken = ($signed(a) > 0);
                        default: taken = (rt == 5'd1) ? !a[31] : (rt == 5'd0) && a[31];
                    endcase
                end
                6'h02, 6'h03: begin
                    wr       = (op == 6'h03);
                    dst      = 5'd31;
                    val      = s.pc + 32'd8;
                    e.redir  = 1'b1;
                    e.target = {s.pc[31:28] + 4'((s.pc + 32'd4) >> 28) - s.pc[31:28],
                                s.instr[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (isBranch && taken) begin
                e.redir  = 1'b1;
                e.target = s.pc + 32'd4 + (se << 2);
            end
            // Register 0 is never written
            if (wr && dst != 5'd0) begin
                modelReg[dst] = val;
                e.wbValid     = 1'b1;
                e.wbReg       = dst;
                e.wbData      = val;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Program generation
    //////////////////////////////////////////////////

    task automatic pushSlot(input slotT s);
        expT e;
        runModel(s, e);
        e.cycle = progQ.size();
        e.secId = curSec;
        progQ.push_back(s);
        expQ.push_back(e);
    endtask

    task automatic emit(input logic [31:0] word);
        slotT s;
        s.valid = 1'b1;
        s.instr = word;
        s.pc    = genPc;
        pushSlot(s);
        genPc = genPc + 32'd4;
    endtask

    // Garbage on the bus with the strobe low
    task automatic idleSlot();
        slotT s;
        s.valid = 1'b0;
        s.instr = $urandom();
        s.pc    = $urandom();
        pushSlot(s);
    endtask

    task automatic setReg(input logic [4:0] r, input logic [31:0] value);
        emit(iType(6'h0D, 5'd0, r, value[31:16]));
        emit(rType(6'h00, 5'd0, r, r, 5'd16));
        emit(iType(6'h0D, r, r, value[15:0]));
    endtask

    task automatic resetAndBubbles();
        curSec = 3'd0;
        repeat (3) idleSlot();
        emit(iType(6'h08, 5'd0, 5'd0, 16'($urandom())));
        emit(rType(6'h20, 5'd0, 5'd0, 5'd1, 5'd0));
        idleSlot();
        emit(iType(6'h0E, 5'd0, 5'd2, 16'h8421));
        idleSlot();
        idleSlot();
        emit(rType(6'h25, 5'd2, 5'd0, 5'd3, 5'd0));
        emit(rType(6'h20, 5'd3, 5'd3, 5'd0, 5'd0));
        idleSlot();
        idleSlot();
    endtask

    // Each op reads the results one and two ahead
    task automatic registerOps();
        logic [5:0] fnList [9] = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2A,
                                   6'h00, 6'h02};
        logic [4:0] prev1;
        logic [4:0] prev2;
        logic [4:0] rd;
        int         k;
        int         r;
        curSec = 3'd1;
        for (r = 1; r <= 8; r++) setReg(5'(r), $urandom());
        prev1 = 5'd8;
        prev2 = 5'd7;
        repeat (24) begin
            k  = $urandom_range(0, 9);
            rd = 5'($urandom_range(1, 8));
            if (k == 9) begin
                emit({6'h1C, prev1, prev2, rd, 5'd0, 6'h02});
            end else begin
                emit(rType(fnList[k], prev1, prev2, rd, 5'($urandom())));
            end
            prev2 = prev1;
            prev1 = rd;
        end
    endtask

    task automatic immediateOps();
        logic [5:0] opList [5] = '{6'h08, 6'h0A, 6'h0C, 6'h0D, 6'h0E};
        logic [4:0] prev;
        logic [4:0] rt;
        curSec = 3'd2;
        prev   = 5'd1;
        repeat (20) begin
            rt = 5'($urandom_range(1, 8));
            emit(iType(opList[$urandom_range(0, 4)], prev, rt, 16'($urandom())));
            prev = rt;
        end
    endtask

    task automatic memoryOps();
        logic [15:0] base;
        curSec = 3'd3;
        repeat (6) begin
            base = 16'($urandom_range(0, 255) * 4);
            setReg(5'd1, $urandom());
            setReg(5'd2, $urandom());
            setReg(5'd3, $urandom());
            emit(iType(6'h08, 5'd0, 5'd9, base));
            emit(iType(6'h2B, 5'd9, 5'd1, 16'd0));
            emit(iType(6'h29, 5'd9, 5'd2, 16'(2 * $urandom_range(0, 1))));
            emit(iType(6'h28, 5'd9, 5'd3, 16'($urandom_range(0, 3))));
            emit(iType(6'h23, 5'd9, 5'd10, 16'd0));
            emit(iType(6'h21, 5'd9, 5'd11, 16'(2 * $urandom_range(0, 1))));
            emit(iType(6'h20, 5'd9, 5'd12, 16'($urandom_range(0, 3))));
            // Consumer right behind the load
            emit(rType(6'h20, 5'd12, 5'd11, 5'd13, 5'd0));
        end
    endtask

    task automatic branchOps();
        logic [31:0] a;
        logic [31:0] b;
        int          c;
        curSec = 3'd4;
        for (c = 0; c < 4; c++) begin
            b = $urandom();
            case (c)
                0:       a = b;
                1:       a = ($urandom() & 32'h7FFF_FFFF) | 32'h1;
                2:       a = $urandom() | 32'h8000_0000;
                default: begin
                    a = 32'h0;
                    b = 32'h0;
                end
            endcase
            setReg(5'd14, a);
            setReg(5'd15, b);
            emit(iType(6'h04, 5'd14, 5'd15, 16'($urandom())));
            emit(iType(6'h05, 5'd14, 5'd15, 16'($urandom())));
            emit(iType(6'h06, 5'd14, 5'd0, 16'($urandom())));
            emit(iType(6'h07, 5'd14, 5'd0, 16'($urandom())));
            emit(iType(6'h01, 5'd14, 5'd1, 16'($urandom())));
            emit(iType(6'h01, 5'd14, 5'd0, 16'($urandom())));
        end
    endtask

    task automatic jumpOps();
        curSec = 3'd5;
        genPc  = $urandom() & 32'hFFFF_FFFC;
        repeat (3) begin
            emit(jType(6'h02, 26'($urandom())));
            emit(jType(6'h03, 26'($urandom())));
            emit(rType(6'h08, 5'd31, 5'd0, 5'd0, 5'd0));
            emit(rType(6'h20, 5'd31, 5'd0, 5'd16, 5'd0));
            setReg(5'd17, $urandom() & 32'hFFFF_FFFC);
            emit(rType(6'h08, 5'd17, 5'd0, 5'd0, 5'd0));
        end
    endtask

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////

    // Expectations follow the two pipeline registers
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exp1 <= '0;
            exp2 <= '0;
        end else begin
            exp1 <= exp0;
            exp2 <= exp1;
        end
    end

    wbCheck: assert property (
        @(posedge clk) disable iff (!arstN)
        (wb.valid === exp2.wbValid) &&
        (!exp2.wbValid || (wb.regIdx == exp2.wbReg && wb.data == exp2.wbData))
    ) else failRun($sformatf(
        "** Error [%s] writeback of issue %0d: expected valid=%0b reg=%0d data=%08h, %s",
        sectionName[$sampled(exp2.secId)], $sampled(exp2.cycle), $sampled(exp2.wbValid),
        $sampled(exp2.wbReg), $sampled(exp2.wbData),
        $sformatf("actual valid=%0b reg=%0d data=%08h", $sampled(wb.valid),
                  $sampled(wb.regIdx), $sampled(wb.data))));

    redirectCheck: assert property (
        @(posedge clk) disable iff (!arstN)
        (redirectValid === exp2.redir) && (!exp2.redir || redirectPc == exp2.target)
    ) else failRun($sformatf(
        "** Error [%s] redirect of issue %0d: expected valid=%0b pc=%08h, %s",
        sectionName[$sampled(exp2.secId)], $sampled(exp2.cycle), $sampled(exp2.redir),
        $sampled(exp2.target),
        $sformatf("actual valid=%0b pc=%08h", $sampled(redirectValid),
                  $sampled(redirectPc))));

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        int timeoutNs;
        int i;
        void'($urandom(32'h5b88));
        clk        = 1'b0;
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        exp0       = '0;
        modelReg   = '{default: '0};
        genPc      = 32'h0040_0000;

        resetAndBubbles();
        registerOps();
        immediateOps();
        memoryOps();
        branchOps();
        jumpOps();

        timeoutNs = (progQ.size() * 20 + ResetCycles) * ClkPeriod;
        fork
            begin
                #(timeoutNs);
                failRun($sformatf("Watchdog expired after %0d ns, program did not finish",
                                  timeoutNs));
            end
        join_none

        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        for (i = 0; i < progQ.size(); i++) begin
            instrValid = progQ[i].valid;
            instr      = progQ[i].instr;
            pc         = progQ[i].pc;
            exp0       = expQ[i];
            @(negedge clk);
        end

        // Drain the pipe so the last expectations get checked
        instrValid = 1'b0;
        exp0       = '0;
        repeat (4) @(negedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* sim.f */
rtl/mipsPkg.sv
rtl/controlDecoder.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/mipsCore.sv
test/coreTb.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  # Shared types first, then the pipeline stages and the top level
  - rtl/mipsPkg.sv
  - rtl/controlDecoder.sv
  - rtl/decodeStage.sv
  - rtl/executeStage.sv
  - rtl/memoryStage.sv
  - rtl/mipsCore.sv

  - target: simulation
    files:
      - test/coreTb.sv
